//--- cpu_axi_rd_top.f
rtl/axi_rd_pkg.sv
rtl/axi_rd_arbiter.sv
rtl/if_fetch_unit.sv
rtl/lsu_read_unit.sv
rtl/axi_rd_rom.sv
rtl/cpu_axi_rd_top.sv
tests/tb_clk_gen.sv
tests/cpu_axi_rd_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = cpu_axi_rd_tb
FILELIST  = cpu_axi_rd_top.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/cpu_axi_rd_tb.sv
`timescale 1ns/100ps

module cpu_axi_rd_tb;

	localparam int          rd_latency = 3;
	localparam logic [31:0] mem_limit  = 32'h0001_0000;
	localparam int          max_beats  = 16;
	localparam int          num_req    = 58;
	localparam int          wd_cycles  = 2 * num_req * (max_beats + rd_latency + 10);

	logic        clk, rst_n;
	logic        fetch_req, fetch_stall, fetch_beat_valid, fetch_done, fetch_err;
	logic [31:0] fetch_addr, fetch_beat_addr;
	logic [7:0]  fetch_len;
	logic [63:0] fetch_beat_data;
	logic        load_req, load_done, load_err;
	logic [31:0] load_addr;
	logic [1:0]  load_size;
	logic [63:0] load_data;

	logic [31:0] exp_addr[$];   // one entry per fetch beat
	logic [63:0] exp_data[$];
	logic        exp_last[$];
	logic        exp_ferr[$];   // one entry per burst
	logic [64:0] exp_load[$];   // {err, data}

	logic [31:0] rng;
	logic        stall_en;
	logic        fetch_in_burst;
	logic        load_owned;
	string       test_name;

	tb_clk_gen u_tb_clk_gen (.clk(clk), .rst_n(rst_n));

	cpu_axi_rd_top #(
		.rd_latency (rd_latency),
		.mem_limit  (mem_limit)
	) u_cpu_axi_rd_top (
		.clk(clk), .rst_n(rst_n),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_len(fetch_len),
		.fetch_stall(fetch_stall), .fetch_beat_valid(fetch_beat_valid),
		.fetch_beat_data(fetch_beat_data), .fetch_beat_addr(fetch_beat_addr),
		.fetch_done(fetch_done), .fetch_err(fetch_err),
		.load_req(load_req), .load_addr(load_addr), .load_size(load_size),
		.load_done(load_done), .load_data(load_data), .load_err(load_err)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// memory content rule with the error region reading zero
	function automatic logic [63:0] rom_word(input logic [31:0] a);
		logic [31:0] w;
		w = {a[31:3], 3'b000};
		if (w >= mem_limit)
			return 64'd0;
		return {~w, w};
	endfunction

	function automatic logic [64:0] expect_load(input logic [31:0] a, input logic [1:0] size);
		logic [63:0] word;
		logic [63:0] mask;
		logic        err;
		word = rom_word(a) >> (8 * a[2:0]);
		case (size)
			2'd0:    mask = 64'h0000_0000_0000_00ff;
			2'd1:    mask = 64'h0000_0000_0000_ffff;
			2'd2:    mask = 64'h0000_0000_ffff_ffff;
			default: mask = 64'hffff_ffff_ffff_ffff;
		endcase
		err = ({a[31:3], 3'b000} >= mem_limit);
		return {err, word & mask};
	endfunction

	task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
			$display("Simulation FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s during test %s", why, test_name);
		$display("Simulation FAILED");
		$fatal(1, "stopped on protocol failure");
	endtask

	task automatic draw(output logic [31:0] r);
		rng = xorshift(rng);
		r = rng;
	endtask

	// drives the request in the current cycle and records its beats
	task automatic queue_fetch(input logic [31:0] a, input logic [7:0] len);
		logic [31:0] w;
		logic        err;
		err = 1'b0;
		for (int i = 0; i <= int'(len); i++) begin
			w = {a[31:3], 3'b000} + 32'(i * 8);
			exp_addr.push_back(w);
			exp_data.push_back(rom_word(w));
			exp_last.push_back(i == int'(len));
			if (w >= mem_limit)
				err = 1'b1;
		end
		exp_ferr.push_back(err);
		fetch_req  = 1'b1;
		fetch_addr = a;
		fetch_len  = len;
	endtask

	task automatic queue_load(input logic [31:0] a, input logic [1:0] size);
		exp_load.push_back(expect_load(a, size));
		load_req  = 1'b1;
		load_addr = a;
		load_size = size;
	endtask

	task automatic next_cycle();
		@(negedge clk);
		fetch_req = 1'b0;
		load_req  = 1'b0;
		if (stall_en) begin
			rng = xorshift(rng);
			fetch_stall = rng[0];
		end else begin
			fetch_stall = 1'b0;
		end
	endtask

	task automatic wait_idle();
		while (exp_data.size() != 0 || exp_load.size() != 0)
			next_cycle();
		next_cycle();
	endtask

	task automatic run_lone_fetches(input int n);
		logic [31:0] r;
		repeat (n) begin
			draw(r);
			queue_fetch({20'd0, r[11:0]}, {4'd0, r[15:12]});
			next_cycle();
			wait_idle();
		end
	endtask

	// compares every response against the expected queues
	always @(posedge clk) begin
		if (rst_n) begin
			if (fetch_beat_valid) begin
				if (exp_data.size() == 0) begin
					abort_run("fetch beat arrived with none expected");
				end else if (load_owned) begin
					abort_run("fetch beat arrived while a load held the bus");
				end else begin
					check_val("fetch_beat_addr", 64'(exp_addr.pop_front()), 64'(fetch_beat_addr));
					check_val("fetch_beat_data", exp_data.pop_front(), fetch_beat_data);
					if (exp_last.pop_front()) begin
						check_val("fetch_done", 64'd1, 64'(fetch_done));
						check_val("fetch_err", 64'(exp_ferr.pop_front()), 64'(fetch_err));
						fetch_in_burst = 1'b0;
					end else begin
						check_val("fetch_done", 64'd0, 64'(fetch_done));
						fetch_in_burst = 1'b1;
					end
				end
			end
			if (load_done) begin
				if (exp_load.size() == 0) begin
					abort_run("load completed with none expected");
				end else if (fetch_in_burst) begin
					abort_run("load completed inside a fetch burst");
				end else begin
					check_val("load_data", 64'(exp_load[0][63:0]), load_data);
					check_val("load_err", 64'(exp_load[0][64]), 64'(load_err));
					void'(exp_load.pop_front());
					load_owned = 1'b0;
				end
			end
			if (u_cpu_axi_rd_top.mem_ar_valid && u_cpu_axi_rd_top.mem_ar_ready)
				load_owned = 1'b1;
		end
	end

	initial begin
		repeat (wd_cycles) @(posedge clk);
		$display("timeout: requests still outstanding after %0d cycles", wd_cycles);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0] r;
		fetch_req      = 1'b0;
		fetch_addr     = '0;
		fetch_len      = '0;
		fetch_stall    = 1'b0;
		load_req       = 1'b0;
		load_addr      = '0;
		load_size      = '0;
		rng            = 32'd22;
		stall_en       = 1'b0;
		fetch_in_burst = 1'b0;
		load_owned     = 1'b0;
		test_name      = "reset";
		@(posedge rst_n);
		repeat (5) begin
			@(negedge clk);
			check_val("fetch_beat_valid", 64'd0, 64'(fetch_beat_valid));
			check_val("fetch_done", 64'd0, 64'(fetch_done));
			check_val("load_done", 64'd0, 64'(load_done));
		end

		test_name = "lone_fetch";
		run_lone_fetches(6);

		test_name = "lone_load";
		for (int sz = 0; sz < 4; sz++) begin
			for (int off = 0; off < 8; off++) begin
				draw(r);
				queue_load({20'd0, r[11:3], 3'(off)}, 2'(sz));
				next_cycle();
				wait_idle();
			end
		end

		test_name = "stall_fetch";
		stall_en = 1'b1;
		run_lone_fetches(6);
		stall_en = 1'b0;

		test_name = "contention";
		for (int k = 0; k < 2; k++) begin
			stall_en = (k == 1);
			draw(r);
			queue_fetch({20'd0, r[11:0]}, {4'd0, r[15:12]});
			queue_load({20'd0, r[27:16]}, r[29:28]); // same cycle so the load wins
			next_cycle();
			wait_idle();
			draw(r);
			queue_fetch({20'd0, r[11:0]}, 8'd15);
			next_cycle();
			while (!fetch_in_burst)
				next_cycle();
			queue_load({20'd0, r[27:16]}, r[29:28]);
			next_cycle();
			wait_idle();
		end
		stall_en = 1'b0;

		test_name = "error_region";
		draw(r);
		queue_fetch(mem_limit + {20'd0, r[11:0]}, {5'd0, r[14:12]});
		next_cycle();
		wait_idle();
		queue_fetch(mem_limit - 32'd16, 8'd3); // crosses into the error region
		next_cycle();
		wait_idle();
		repeat (4) begin
			draw(r);
			queue_load(mem_limit + {20'd0, r[11:0]}, r[13:12]);
			next_cycle();
			wait_idle();
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

//--- rtl/cpu_axi_rd_top.sv
`timescale 1ns/100ps

module cpu_axi_rd_top #(
	parameter int          rd_latency = 3,
	parameter logic [31:0] mem_limit  = 32'h0001_0000
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          fetch_req,
	input  logic [axi_rd_pkg::addr_w-1:0] fetch_addr,
	input  logic [axi_rd_pkg::len_w-1:0]  fetch_len,
	input  logic                          fetch_stall,
	output logic                          fetch_beat_valid,
	output logic [axi_rd_pkg::data_w-1:0] fetch_beat_data,
	output logic [axi_rd_pkg::addr_w-1:0] fetch_beat_addr,
	output logic                          fetch_done,
	output logic                          fetch_err,
	input  logic                          load_req,
	input  logic [axi_rd_pkg::addr_w-1:0] load_addr,
	input  logic [axi_rd_pkg::size_w-1:0] load_size,
	output logic                          load_done,
	output logic [axi_rd_pkg::data_w-1:0] load_data,
	output logic                          load_err
);

	// fetch side
	logic                          if_ar_valid, if_ar_ready;
	logic [axi_rd_pkg::addr_w-1:0] if_ar_addr;
	logic [axi_rd_pkg::len_w-1:0]  if_ar_len;
	logic [axi_rd_pkg::size_w-1:0] if_ar_size;
	logic                          if_r_valid, if_r_ready, if_r_last;
	logic [axi_rd_pkg::data_w-1:0] if_r_data;
	logic [axi_rd_pkg::addr_w-1:0] if_r_addr;
	logic [axi_rd_pkg::resp_w-1:0] if_r_resp;

	// load side
	logic                          mem_ar_valid, mem_ar_ready;
	logic [axi_rd_pkg::addr_w-1:0] mem_ar_addr;
	logic [axi_rd_pkg::len_w-1:0]  mem_ar_len;
	logic [axi_rd_pkg::size_w-1:0] mem_ar_size;
	logic                          mem_r_valid, mem_r_ready, mem_r_last;
	logic [axi_rd_pkg::data_w-1:0] mem_r_data;
	logic [axi_rd_pkg::addr_w-1:0] mem_r_addr;
	logic [axi_rd_pkg::resp_w-1:0] mem_r_resp;

	// shared port toward memory
	logic                          bus_ar_valid, bus_ar_ready;
	logic [axi_rd_pkg::addr_w-1:0] bus_ar_addr;
	logic [axi_rd_pkg::len_w-1:0]  bus_ar_len;
	logic [axi_rd_pkg::size_w-1:0] bus_ar_size;
	logic                          bus_r_valid, bus_r_ready, bus_r_last;
	logic [axi_rd_pkg::data_w-1:0] bus_r_data;
	logic [axi_rd_pkg::addr_w-1:0] bus_r_addr;
	logic [axi_rd_pkg::resp_w-1:0] bus_r_resp;

	if_fetch_unit u_if_fetch_unit (.*);

	lsu_read_unit u_lsu_read_unit (.*);

	axi_rd_arbiter u_axi_rd_arbiter (.*);

	axi_rd_rom #(
		.rd_latency (rd_latency),
		.mem_limit  (mem_limit)
	) u_axi_rd_rom (.*);

endmodule

//--- rtl/axi_rd_rom.sv
`timescale 1ns/100ps

module axi_rd_rom #(
	parameter int          rd_latency = 3,
	parameter logic [31:0] mem_limit  = 32'h0001_0000
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          bus_ar_valid,
	input  logic [axi_rd_pkg::addr_w-1:0] bus_ar_addr,
	input  logic [axi_rd_pkg::len_w-1:0]  bus_ar_len,
	input  logic [axi_rd_pkg::size_w-1:0] bus_ar_size,
	input  logic                          bus_r_ready,
	output logic                          bus_ar_ready,
	output logic                          bus_r_valid,
	output logic [axi_rd_pkg::data_w-1:0] bus_r_data,
	output logic [axi_rd_pkg::addr_w-1:0] bus_r_addr,
	output logic [axi_rd_pkg::resp_w-1:0] bus_r_resp,
	output logic                          bus_r_last
);

	localparam int lat_w = (rd_latency > 1) ? $clog2(rd_latency + 1) : 1;

	axi_rd_pkg::rom_state_t        state_q;
	logic [lat_w-1:0]              lat_cnt;
	logic [axi_rd_pkg::len_w-1:0]  beat_cnt;
	logic [axi_rd_pkg::len_w-1:0]  len_q;
	logic [axi_rd_pkg::size_w-1:0] size_q;
	logic [axi_rd_pkg::addr_w-1:0] cur_addr;     // address of the beat on the bus
	logic [axi_rd_pkg::addr_w-1:0] word_addr;
	logic [axi_rd_pkg::addr_w-1:0] step;
	logic                          in_error;
	logic                          beat;

	assign bus_ar_ready = (state_q == axi_rd_pkg::rom_idle);
	assign bus_r_valid  = (state_q == axi_rd_pkg::rom_burst);
	assign beat         = bus_r_valid & bus_r_ready;

	assign word_addr = {cur_addr[axi_rd_pkg::addr_w-1:3], 3'b000};
	assign step      = axi_rd_pkg::addr_w'(1) << size_q;
	assign in_error  = (word_addr >= mem_limit);

	// contents derived from the address itself
	assign bus_r_data = in_error ? '0 : {~word_addr, word_addr};
	assign bus_r_resp = in_error ? axi_rd_pkg::resp_slverr : axi_rd_pkg::resp_okay;
	assign bus_r_addr = cur_addr;
	assign bus_r_last = (beat_cnt == len_q);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= axi_rd_pkg::rom_idle;
		end else begin
			case (state_q)
				axi_rd_pkg::rom_idle: begin
					if (bus_ar_valid)
						state_q <= axi_rd_pkg::rom_wait;
				end
				axi_rd_pkg::rom_wait: begin
					if (lat_cnt == '0)
						state_q <= axi_rd_pkg::rom_burst;
				end
				axi_rd_pkg::rom_burst: begin
					if (beat && bus_r_last)
						state_q <= axi_rd_pkg::rom_idle;
				end
				default: state_q <= axi_rd_pkg::rom_idle;
			endcase
		end
	end

	// counters and burst context
	always_ff @(posedge clk) begin
		if (bus_ar_valid && bus_ar_ready) begin
			lat_cnt  <= lat_w'(rd_latency - 1); // first beat rd_latency cycles out
			beat_cnt <= '0;
			len_q    <= bus_ar_len;
			size_q   <= bus_ar_size;
			cur_addr <= bus_ar_addr;
		end else if (state_q == axi_rd_pkg::rom_wait) begin
			if (lat_cnt != '0)
				lat_cnt <= lat_cnt - 1'b1;
		end else if (beat && !bus_r_last) begin
			beat_cnt <= beat_cnt + 1'b1;
			cur_addr <= cur_addr + step; // incrementing burst
		end
	end

endmodule

//--- rtl/lsu_read_unit.sv
`timescale 1ns/100ps

module lsu_read_unit (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          load_req,
	input  logic [axi_rd_pkg::addr_w-1:0] load_addr,
	input  logic [axi_rd_pkg::size_w-1:0] load_size,
	input  logic                          mem_ar_ready,
	input  logic                          mem_r_valid,
	input  logic [axi_rd_pkg::data_w-1:0] mem_r_data,
	input  logic [axi_rd_pkg::addr_w-1:0] mem_r_addr,
	input  logic [axi_rd_pkg::resp_w-1:0] mem_r_resp,
	input  logic                          mem_r_last,
	output logic                          mem_ar_valid,
	output logic [axi_rd_pkg::addr_w-1:0] mem_ar_addr,
	output logic [axi_rd_pkg::len_w-1:0]  mem_ar_len,
	output logic [axi_rd_pkg::size_w-1:0] mem_ar_size,
	output logic                          mem_r_ready,
	output logic                          load_done,
	output logic [axi_rd_pkg::data_w-1:0] load_data,
	output logic                          load_err
);

	axi_rd_pkg::req_state_t        state_q;
	logic [axi_rd_pkg::addr_w-1:0] addr_q;
	logic [axi_rd_pkg::size_w-1:0] size_q;
	logic [axi_rd_pkg::data_w-1:0] data_q;   // last result, held until next load
	logic                          err_q;
	logic [axi_rd_pkg::data_w-1:0] shifted;
	logic [axi_rd_pkg::data_w-1:0] extended;
	logic                          beat;
	logic                          addr_match;

	assign mem_ar_valid = (state_q == axi_rd_pkg::req_addr);
	assign mem_ar_addr  = {addr_q[axi_rd_pkg::addr_w-1:3], 3'b000};
	assign mem_ar_len   = '0;    // always a single beat
	assign mem_ar_size  = size_q;
	assign mem_r_ready  = (state_q == axi_rd_pkg::req_data);

	// returned beat must be the word we asked for
	assign addr_match = (mem_r_addr[axi_rd_pkg::addr_w-1:3] == addr_q[axi_rd_pkg::addr_w-1:3]);
	assign beat       = mem_r_valid & mem_r_ready & mem_r_last;

	// byte lane select then zero extension
	always_comb begin
		shifted = mem_r_data >> {addr_q[2:0], 3'b000};
		case (size_q)
			2'd0:    extended = {56'd0, shifted[7:0]};
			2'd1:    extended = {48'd0, shifted[15:0]};
			2'd2:    extended = {32'd0, shifted[31:0]};
			default: extended = shifted;
		endcase
	end

	assign load_done = beat;
	assign load_data = beat ? extended : data_q;
	assign load_err  = beat ? ((mem_r_resp != axi_rd_pkg::resp_okay) | ~addr_match) : err_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= axi_rd_pkg::req_idle;
		end else begin
			case (state_q)
				axi_rd_pkg::req_idle:
					if (load_req) state_q <= axi_rd_pkg::req_addr;
				axi_rd_pkg::req_addr:
					if (mem_ar_ready) state_q <= axi_rd_pkg::req_data;
				axi_rd_pkg::req_data:
					if (beat) state_q <= axi_rd_pkg::req_idle;
				default: state_q <= axi_rd_pkg::req_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == axi_rd_pkg::req_idle && load_req) begin
			addr_q <= load_addr;
			size_q <= load_size;
		end
		if (beat) begin
			data_q <= load_data;
			err_q  <= load_err;
		end
	end

endmodule

//--- rtl/if_fetch_unit.sv
`timescale 1ns/100ps

module if_fetch_unit (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          fetch_req,
	input  logic [axi_rd_pkg::addr_w-1:0] fetch_addr,
	input  logic [axi_rd_pkg::len_w-1:0]  fetch_len,
	input  logic                          fetch_stall,
	input  logic                          if_ar_ready,
	input  logic                          if_r_valid,
	input  logic [axi_rd_pkg::data_w-1:0] if_r_data,
	input  logic [axi_rd_pkg::addr_w-1:0] if_r_addr,
	input  logic [axi_rd_pkg::resp_w-1:0] if_r_resp,
	input  logic                          if_r_last,
	output logic                          if_ar_valid,
	output logic [axi_rd_pkg::addr_w-1:0] if_ar_addr,
	output logic [axi_rd_pkg::len_w-1:0]  if_ar_len,
	output logic [axi_rd_pkg::size_w-1:0] if_ar_size,
	output logic                          if_r_ready,
	output logic                          fetch_beat_valid,
	output logic [axi_rd_pkg::data_w-1:0] fetch_beat_data,
	output logic [axi_rd_pkg::addr_w-1:0] fetch_beat_addr,
	output logic                          fetch_done,
	output logic                          fetch_err
);

	axi_rd_pkg::req_state_t        state_q;
	logic [axi_rd_pkg::addr_w-1:0] addr_q;
	logic [axi_rd_pkg::len_w-1:0]  len_q;
	logic                          err_q;    // any bad response so far
	logic                          beat;
	logic                          beat_err;

	// whole instruction words only
	assign if_ar_valid = (state_q == axi_rd_pkg::req_addr);
	assign if_ar_addr  = {addr_q[axi_rd_pkg::addr_w-1:3], 3'b000};
	assign if_ar_len   = len_q;
	assign if_ar_size  = 2'd3;

	assign if_r_ready = (state_q == axi_rd_pkg::req_data) & ~fetch_stall;
	assign beat       = if_r_valid & if_r_ready;
	assign beat_err   = (if_r_resp != axi_rd_pkg::resp_okay);

	assign fetch_beat_valid = beat;
	assign fetch_beat_data  = if_r_data;
	assign fetch_beat_addr  = if_r_addr;
	assign fetch_done       = beat & if_r_last;
	assign fetch_err        = fetch_done & (err_q | beat_err);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= axi_rd_pkg::req_idle;
			err_q   <= 1'b0;
		end else begin
			case (state_q)
				axi_rd_pkg::req_idle: begin
					if (fetch_req) begin
						state_q <= axi_rd_pkg::req_addr;
						err_q   <= 1'b0;
					end
				end
				axi_rd_pkg::req_addr: begin
					if (if_ar_ready)
						state_q <= axi_rd_pkg::req_data;
				end
				axi_rd_pkg::req_data: begin
					if (beat) begin
						err_q <= err_q | beat_err;
						if (if_r_last)
							state_q <= axi_rd_pkg::req_idle;
					end
				end
				default: state_q <= axi_rd_pkg::req_idle;
			endcase
		end
	end

	// request payload, taken only when idle
	always_ff @(posedge clk) begin
		if (state_q == axi_rd_pkg::req_idle && fetch_req) begin
			addr_q <= fetch_addr;
			len_q  <= fetch_len;
		end
	end

endmodule

//--- rtl/axi_rd_arbiter.sv
`timescale 1ns/100ps

module axi_rd_arbiter (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          if_ar_valid,
	input  logic [axi_rd_pkg::addr_w-1:0] if_ar_addr,
	input  logic [axi_rd_pkg::len_w-1:0]  if_ar_len,
	input  logic [axi_rd_pkg::size_w-1:0] if_ar_size,
	input  logic                          if_r_ready,
	input  logic                          mem_ar_valid,
	input  logic [axi_rd_pkg::addr_w-1:0] mem_ar_addr,
	input  logic [axi_rd_pkg::len_w-1:0]  mem_ar_len,
	input  logic [axi_rd_pkg::size_w-1:0] mem_ar_size,
	input  logic                          mem_r_ready,
	input  logic                          bus_ar_ready,
	input  logic                          bus_r_valid,
	input  logic [axi_rd_pkg::data_w-1:0] bus_r_data,
	input  logic [axi_rd_pkg::addr_w-1:0] bus_r_addr,
	input  logic [axi_rd_pkg::resp_w-1:0] bus_r_resp,
	input  logic                          bus_r_last,
	output logic                          if_ar_ready,
	output logic                          if_r_valid,
	output logic [axi_rd_pkg::data_w-1:0] if_r_data,
	output logic [axi_rd_pkg::addr_w-1:0] if_r_addr,
	output logic [axi_rd_pkg::resp_w-1:0] if_r_resp,
	output logic                          if_r_last,
	output logic                          mem_ar_ready,
	output logic                          mem_r_valid,
	output logic [axi_rd_pkg::data_w-1:0] mem_r_data,
	output logic [axi_rd_pkg::addr_w-1:0] mem_r_addr,
	output logic [axi_rd_pkg::resp_w-1:0] mem_r_resp,
	output logic                          mem_r_last,
	output logic                          bus_ar_valid,
	output logic [axi_rd_pkg::addr_w-1:0] bus_ar_addr,
	output logic [axi_rd_pkg::len_w-1:0]  bus_ar_len,
	output logic [axi_rd_pkg::size_w-1:0] bus_ar_size,
	output logic                          bus_r_ready
);

	axi_rd_pkg::owner_t owner_q;
	logic               addr_open;
	logic               pick_mem;

	assign addr_open = (owner_q == axi_rd_pkg::own_none);
	assign pick_mem  = mem_ar_valid; // load stage wins a tie

	// address channel only opens between transactions
	assign bus_ar_addr  = pick_mem ? mem_ar_addr : if_ar_addr;
	assign bus_ar_len   = pick_mem ? mem_ar_len  : if_ar_len;
	assign bus_ar_size  = pick_mem ? mem_ar_size : if_ar_size;
	assign bus_ar_valid = addr_open & (mem_ar_valid | if_ar_valid);
	assign mem_ar_ready = addr_open & pick_mem & bus_ar_ready;
	assign if_ar_ready  = addr_open & ~pick_mem & bus_ar_ready;

	always_comb begin
		if_r_valid  = 1'b0;
		if_r_data   = '0;
		if_r_addr   = '0;
		if_r_resp   = '0;
		if_r_last   = 1'b0;
		mem_r_valid = 1'b0;
		mem_r_data  = '0;
		mem_r_addr  = '0;
		mem_r_resp  = '0;
		mem_r_last  = 1'b0;
		bus_r_ready = 1'b0;
		if (owner_q == axi_rd_pkg::own_if) begin
			if_r_valid  = bus_r_valid;
			if_r_data   = bus_r_data;
			if_r_addr   = bus_r_addr;
			if_r_resp   = bus_r_resp;
			if_r_last   = bus_r_last;
			bus_r_ready = if_r_ready;
		end else if (owner_q == axi_rd_pkg::own_mem) begin
			mem_r_valid = bus_r_valid;
			mem_r_data  = bus_r_data;
			mem_r_addr  = bus_r_addr;
			mem_r_resp  = bus_r_resp;
			mem_r_last  = bus_r_last;
			bus_r_ready = mem_r_ready;
		end
	end

	// ownership held from address handshake to the last beat
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			owner_q <= axi_rd_pkg::own_none;
		end else if (bus_ar_valid && bus_ar_ready) begin
			owner_q <= pick_mem ? axi_rd_pkg::own_mem : axi_rd_pkg::own_if;
		end else if (bus_r_valid && bus_r_ready && bus_r_last) begin
			owner_q <= axi_rd_pkg::own_none;
		end
	end

endmodule

//--- rtl/axi_rd_pkg.sv
package axi_rd_pkg;

	// bus geometry
	localparam int addr_w = 32;
	localparam int data_w = 64;
	localparam int len_w  = 8;   // beats minus one
	localparam int size_w = 2;   // log2 of bytes per beat
	localparam int resp_w = 2;

	localparam logic [resp_w-1:0] resp_okay   = 2'd0;
	localparam logic [resp_w-1:0] resp_slverr = 2'd2;

	// who holds the shared read port
	typedef enum logic [1:0] {
		own_none,
		own_if,
		own_mem
	} owner_t;

	// memory slave sequencing
	typedef enum logic [1:0] {
		rom_idle,
		rom_wait,   // counting down the access latency
		rom_burst
	} rom_state_t;

	// common to fetch and load units
	typedef enum logic [1:0] {
		req_idle,
		req_addr,
		req_data
	} req_state_t;

endpackage
